//--- video_upscan.f
+incdir+.
video_upscan_pkg.sv
line_buf_if.sv
line_writer.sv
line_buffer.sv
output_timing.sv
stretch_reader.sv
video_upscan.sv
tb_video_upscan.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the upscaler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal \
    -f video_upscan.f \
    --top-module tb_video_upscan \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
else
    exit 1
fi

//--- tb_video_upscan.sv
// Upscaler testbench
`timescale 1ns/1ps
`default_nettype none
`include "video_upscan_defines.svh"

module tb_video_upscan;
    import video_upscan_pkg::*;

    localparam int NUM_ROWS = 5;
    localparam int CAP_LINE = 6;                // First captured output line
    localparam int LINE_LEN = 2 * `H_TOTAL;     // Input line period

    typedef enum int {PAT_FLAT, PAT_RAMP, PAT_RAND} pattern_t;

    typedef enum int {WATCH_HS, WATCH_VS, WATCH_DE} watch_t;

    typedef struct {
        video_mode_t mode;
        pattern_t    kind;
        rgb_t        base;
    } row_t;

    logic        DCLK;
    logic        RESET_n;
    video_mode_t mode;
    pixel_t      in_r, in_g, in_b;
    logic        in_hs_n, in_vs_n;
    pixel_t      out_r, out_g, out_b;
    logic        out_hs_n, out_vs_n, out_de;

    row_t rows [0:NUM_ROWS-1];
    rgb_t line_pix [0:`IN_WIDTH_720-1];         // Same pattern on every input line
    rgb_t exp_pix [0:`H_DISP-1];
    rgb_t cap [0:1][0:`H_DISP-1];
    int   cap_len [0:1];
    int   errors;
    int   tests;
    int   err_mark;

    video_upscan video_upscan_i (
        .DCLK     (DCLK),
        .RESET_n  (RESET_n),
        .mode     (mode),
        .in_r     (in_r),
        .in_g     (in_g),
        .in_b     (in_b),
        .in_hs_n  (in_hs_n),
        .in_vs_n  (in_vs_n),
        .out_r    (out_r),
        .out_g    (out_g),
        .out_b    (out_b),
        .out_hs_n (out_hs_n),
        .out_vs_n (out_vs_n),
        .out_de   (out_de)
    );

    always #5 DCLK = ~DCLK;

    task automatic check_rgb(string name, rgb_t exp, rgb_t act);
        if (exp !== act) begin
            errors++;
            $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_level(string name, logic exp, logic act);
        if (exp !== act) begin
            errors++;
            $display("Error at %0t ns: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (exp != act) begin
            errors++;
            $display("Error at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic report_timeout(string what);
        errors++;
        $display("Timed out while waiting for %s", what);
    endtask

    // Build one input line for the row
    task automatic make_line(row_t row, int width);
        for (int x = 0; x < width; x++) begin
            case (row.kind)
                PAT_FLAT: line_pix[x] = row.base;
                PAT_RAMP: begin
                    line_pix[x].r = pixel_t'(row.base.r + x);
                    line_pix[x].g = pixel_t'(row.base.g + 3 * x);
                    line_pix[x].b = pixel_t'(row.base.b - x);
                end
                default:  line_pix[x] = rgb_t'(24'($urandom));
            endcase
        end
    endtask

    function automatic pixel_t mix(int s, pixel_t left, pixel_t right);
        int sum;
        sum = s * int'(left) + (8 - s) * int'(right);
        return pixel_t'(sum / 8);
    endfunction

    // Expected output line from the group and phase rule
    task automatic make_expected(video_mode_t m);
        int g;
        int s;
        for (int j = 0; j < `H_DISP; j++) begin
            g = j / 9;
            s = j % 9;
            if (m == MODE_720) begin
                exp_pix[j] = line_pix[j];
            end else if (s == 0) begin
                exp_pix[j] = line_pix[8 * g];
            end else if (s == 8) begin
                exp_pix[j] = line_pix[8 * g + 7];
            end else begin
                exp_pix[j].r = mix(s, line_pix[8*g+s-1].r, line_pix[8*g+s].r);
                exp_pix[j].g = mix(s, line_pix[8*g+s-1].g, line_pix[8*g+s].g);
                exp_pix[j].b = mix(s, line_pix[8*g+s-1].b, line_pix[8*g+s].b);
            end
        end
    endtask

    task automatic drive_frame(int start, int width);
        for (int l = 0; l < 4; l++) begin
            for (int c = 0; c < LINE_LEN; c++) begin
                @(negedge DCLK);
                in_hs_n = (c < `H_SYNC) ? 1'b0 : 1'b1;
                in_vs_n = (l == 0 && c < `H_SYNC) ? 1'b0 : 1'b1;    // Vsync with line 0
                if (c >= start && c < start + width) begin
                    {in_r, in_g, in_b} = line_pix[c - start];
                end else begin
                    {in_r, in_g, in_b} = '0;
                end
            end
        end
    endtask

    // Current level of one DUT sync or enable output
    function automatic logic out_level(watch_t w);
        case (w)
            WATCH_HS: return out_hs_n;
            WATCH_VS: return out_vs_n;
            default:  return out_de;
        endcase
    endfunction

    task automatic wait_level(watch_t w, logic lvl, int limit, string what);
        int n;
        n = 0;
        while (out_level(w) !== lvl && n < limit) begin
            @(negedge DCLK);
            n++;
        end
        if (out_level(w) !== lvl) begin
            report_timeout(what);
        end
    endtask

    task automatic capture_lines();
        int n;
        wait_level(WATCH_VS, 1'b0, 20, "output vsync");
        for (int k = 0; k <= CAP_LINE; k++) begin
            wait_level(WATCH_HS, 1'b0, LINE_LEN, "output hsync low");
            wait_level(WATCH_HS, 1'b1, LINE_LEN, "output hsync high");
        end
        for (int k = 0; k < 2; k++) begin
            wait_level(WATCH_DE, 1'b1, LINE_LEN, "data enable");
            n = 0;
            while (out_de === 1'b1 && n < `H_DISP + 10) begin
                if (n < `H_DISP) cap[k][n] = {out_r, out_g, out_b};
                n++;
                @(negedge DCLK);
            end
            cap_len[k] = n;
        end
    endtask

    task automatic measure_sync();
        int n;
        n = 0;
        while (out_vs_n !== 1'b0 && n < 20) begin
            @(negedge DCLK);
            n++;
        end
        // Input vsync goes low at the first falling edge
        check_level("out_vs_n latency within 4", 1'b1, (n - 1) <= 4);
        n = 0;
        while (out_vs_n === 1'b0 && n < 4 * `H_TOTAL) begin
            @(negedge DCLK);
            n++;
        end
        check_count("out_vs_n low cycles", `V_SYNC * `H_TOTAL, n);
        wait_level(WATCH_HS, 1'b0, LINE_LEN, "hsync fall");
        n = 0;
        while (out_hs_n === 1'b0 && n < LINE_LEN) begin
            @(negedge DCLK);
            n++;
        end
        check_count("out_hs_n low cycles", `H_SYNC, n);
        while (out_hs_n === 1'b1 && n < 2 * LINE_LEN) begin
            @(negedge DCLK);
            n++;
        end
        check_count("out_hs_n period", `H_TOTAL, n);
    endtask

    initial begin
        int start;
        int width;
        void'($urandom(8631));
        rows[0] = '{MODE_720, PAT_RAMP, rgb_t'(24'h10_40_F0)};
        rows[1] = '{MODE_720, PAT_RAND, rgb_t'(24'h00_00_00)};
        rows[2] = '{MODE_640, PAT_FLAT, rgb_t'(24'h5A_A5_3C)};
        rows[3] = '{MODE_640, PAT_RAMP, rgb_t'(24'h00_80_FF)};
        rows[4] = '{MODE_640, PAT_RAND, rgb_t'(24'h00_00_00)};
        errors = 0;
        tests  = 0;
        DCLK = 1'b0;
        RESET_n = 1'b0;
        mode = MODE_720;
        {in_r, in_g, in_b} = '0;
        in_hs_n = 1'b1;
        in_vs_n = 1'b1;
        repeat (8) @(negedge DCLK);
        RESET_n = 1'b1;                         // Outputs still hold their reset values
        check_level("out_hs_n", 1'b1, out_hs_n);
        check_level("out_vs_n", 1'b1, out_vs_n);
        check_level("out_de", 1'b0, out_de);
        check_rgb("out_rgb", '0, {out_r, out_g, out_b});
        tests++;
        $display("Test reset state done, errors so far %0d", errors);

        for (int r = 0; r < NUM_ROWS; r++) begin
            err_mark = errors;
            mode  = rows[r].mode;
            start = (mode == MODE_640) ? `IN_START_640 : `IN_START_720;
            width = (mode == MODE_640) ? `IN_WIDTH_640 : `IN_WIDTH_720;
            make_line(rows[r], width);
            make_expected(mode);
            fork
                drive_frame(start, width);
                capture_lines();
                if (r == 0) measure_sync();     // Raster timing on the first frame
            join
            for (int k = 0; k < 2; k++) begin
                check_count("out_de cycles per line", `H_DISP, cap_len[k]);
                for (int j = 0; j < `H_DISP; j++) begin
                    check_rgb($sformatf("out_rgb line %0d pixel %0d", CAP_LINE + k, j),
                              exp_pix[j], cap[k][j]);
                end
            end
            tests++;
            $display("Test frame %0d mode %s done, %0d errors", r, mode.name(),
                     errors - err_mark);
        end

        $display("Tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- video_upscan.sv
// Line doubling upscaler top
`timescale 1ns/1ps
`default_nettype none

module video_upscan
    import video_upscan_pkg::*;
(
    input  wire              DCLK,
    input  wire              RESET_n,
    input  wire video_mode_t mode,
    input  wire pixel_t      in_r,
    input  wire pixel_t      in_g,
    input  wire pixel_t      in_b,
    input  wire              in_hs_n,
    input  wire              in_vs_n,
    output pixel_t           out_r,
    output pixel_t           out_g,
    output pixel_t           out_b,
    output logic             out_hs_n,
    output logic             out_vs_n,
    output logic             out_de
);

    rgb_t in_rgb;
    rgb_t out_rgb;
    logic line_start;
    logic active;
    logic rd_bank;

    line_buf_if buf_bus ();

    assign in_rgb = '{r: in_r, g: in_g, b: in_b};
    assign out_r  = out_rgb.r;
    assign out_g  = out_rgb.g;
    assign out_b  = out_rgb.b;

    line_writer line_writer_i (
        .DCLK    (DCLK),
        .RESET_n (RESET_n),
        .in_rgb  (in_rgb),
        .in_hs_n (in_hs_n),
        .in_vs_n (in_vs_n),
        .mode    (mode),
        .buf_wr  (buf_bus.writer)
    );

    line_buffer line_buffer_i (
        .DCLK (DCLK),
        .mem  (buf_bus.memory)
    );

    output_timing output_timing_i (
        .DCLK       (DCLK),
        .RESET_n    (RESET_n),
        .in_vs_n    (in_vs_n),
        .out_hs_n   (out_hs_n),
        .out_vs_n   (out_vs_n),
        .line_start (line_start),
        .active     (active),
        .rd_bank    (rd_bank)
    );

    stretch_reader stretch_reader_i (
        .DCLK       (DCLK),
        .RESET_n    (RESET_n),
        .mode       (mode),
        .line_start (line_start),
        .active     (active),
        .rd_bank    (rd_bank),
        .buf_rd     (buf_bus.reader),
        .out_rgb    (out_rgb),
        .out_de     (out_de)
    );

endmodule

`default_nettype wire

//--- stretch_reader.sv
// Line readback and 9/8 stretch
`timescale 1ns/1ps
`default_nettype none
`include "video_upscan_defines.svh"

module stretch_reader
    import video_upscan_pkg::*;
(
    input  wire              DCLK,
    input  wire              RESET_n,
    input  wire video_mode_t mode,
    input  wire              line_start,
    input  wire              active,
    input  wire              rd_bank,
    line_buf_if.reader       buf_rd,
    output rgb_t             out_rgb,
    output logic             out_de
);

    logic [9:0] pix_cnt;        // Fetches issued this line
    logic       fetch;
    phase_t     phase;          // Phase of the word being addressed
    phase_t     phase_d;        // Phase of the word on rd_data
    logic       de_d;
    rgb_t       prev;           // Word before rd_data

    // Weighted mix (s*prev + (8-s)*cur) / 8, truncated
    function automatic pixel_t blend(pixel_t p, pixel_t c, phase_t s);
        logic [10:0] w;
        logic [10:0] sum;
        w   = 11'(s);
        sum = w * 11'(p) + (11'd8 - w) * 11'(c);
        return pixel_t'(sum >> 3);
    endfunction

    function automatic rgb_t blend_rgb(rgb_t p, rgb_t c, phase_t s);
        rgb_t m;
        m.r = blend(p.r, c.r, s);
        m.g = blend(p.g, c.g, s);
        m.b = blend(p.b, c.b, s);
        return m;
    endfunction

    assign fetch = active && (pix_cnt != 10'(`H_DISP));

    // Address and phase stepping
    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            buf_rd.rd_addr <= '0;
            phase          <= PH_0;
            pix_cnt        <= '0;
        end else if (line_start) begin
            buf_rd.rd_addr <= rd_bank ? `BUF_ADDR_W'(`BUF_WIDTH) : '0;
            phase          <= PH_0;
            pix_cnt        <= '0;
        end else if (fetch) begin
            pix_cnt <= pix_cnt + 10'd1;
            if (mode == MODE_720) begin
                buf_rd.rd_addr <= buf_rd.rd_addr + 1'b1;    // Phase stays PH_0
            end else begin
                if (phase != PH_7) begin
                    buf_rd.rd_addr <= buf_rd.rd_addr + 1'b1;
                end
                phase <= phase.next();                      // PH_8 wraps to PH_0
            end
        end
    end

    // Previous word for the left-hand tap
    always_ff @(posedge DCLK) begin
        prev <= buf_rd.rd_data;
    end

    // PH_0 selects rd_data alone, PH_8 sees the same word twice
    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            de_d    <= 1'b0;
            phase_d <= PH_0;
            out_de  <= 1'b0;
            out_rgb <= '0;
        end else begin
            de_d    <= fetch;
            phase_d <= phase;
            out_de  <= de_d;
            out_rgb <= de_d ? blend_rgb(prev, buf_rd.rd_data, phase_d) : '0;
        end
    end

endmodule

`default_nettype wire

//--- output_timing.sv
// Output raster timing
`timescale 1ns/1ps
`default_nettype none
`include "video_upscan_defines.svh"

module output_timing (
    input  wire  DCLK,
    input  wire  RESET_n,
    input  wire  in_vs_n,
    output logic out_hs_n,
    output logic out_vs_n,
    output logic line_start,
    output logic active,
    output logic rd_bank
);

    logic       vs_q;
    logic       vs_d;
    logic       vs_fall;
    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic [1:0] line_cnt;       // Two output lines per bank
    logic       h_wrap;
    logic       fetch_win;

    assign vs_fall = vs_d & ~vs_q;
    assign h_wrap  = (h_cnt == 10'(`H_TOTAL - 1));

    // Two cycles early to cover buffer read and output register
    assign fetch_win = (h_cnt >= 10'(`H_ERASE - 2)) &&
                       (h_cnt <  10'(`H_ERASE + `H_DISP - 2));

    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            vs_q <= 1'b1;
            vs_d <= 1'b1;
        end else begin
            vs_q <= in_vs_n;
            vs_d <= vs_q;
        end
    end

    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            h_cnt    <= '0;
            v_cnt    <= 10'(`V_SYNC);   // Start outside vsync
            line_cnt <= '0;
        end else if (vs_fall) begin
            h_cnt    <= '0;             // Input frame restarts the raster
            v_cnt    <= '0;
            line_cnt <= '0;
        end else if (h_wrap) begin
            h_cnt    <= '0;
            v_cnt    <= (v_cnt == 10'(`V_TOTAL - 1)) ? '0 : v_cnt + 10'd1;
            line_cnt <= line_cnt + 2'd1;
        end else begin
            h_cnt    <= h_cnt + 10'd1;
        end
    end

    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            out_hs_n   <= 1'b1;
            out_vs_n   <= 1'b1;
            line_start <= 1'b0;
            active     <= 1'b0;
            rd_bank    <= 1'b0;
        end else begin
            out_hs_n   <= (h_cnt >= 10'(`H_SYNC));
            out_vs_n   <= (v_cnt >= 10'(`V_SYNC));
            line_start <= (h_cnt == 10'd1);
            active     <= fetch_win;
            if (h_cnt == 10'd1) begin
                rd_bank <= line_cnt[1];     // Stable until next line
            end
        end
    end

endmodule

`default_nettype wire

//--- line_buffer.sv
// Two-bank RGB line memory
`timescale 1ns/1ps
`default_nettype none
`include "video_upscan_defines.svh"

module line_buffer
    import video_upscan_pkg::*;
(
    input  wire         DCLK,
    line_buf_if.memory  mem
);

    localparam int DEPTH = 2 * `BUF_WIDTH;

    rgb_t ram [0:DEPTH-1];      // Bank 0 then bank 1

    // Write port, owned by the line writer
    always_ff @(posedge DCLK) begin
        if (mem.wr_en) begin
            ram[mem.wr_addr] <= mem.wr_data;
        end
    end

    // Read port, registered output
    always_ff @(posedge DCLK) begin
        mem.rd_data <= ram[mem.rd_addr];
    end

endmodule

`default_nettype wire

//--- line_writer.sv
// Input line capture
`timescale 1ns/1ps
`default_nettype none
`include "video_upscan_defines.svh"

module line_writer
    import video_upscan_pkg::*;
(
    input  wire              DCLK,
    input  wire              RESET_n,
    input  wire rgb_t        in_rgb,
    input  wire              in_hs_n,
    input  wire              in_vs_n,
    input  wire video_mode_t mode,
    line_buf_if.writer       buf_wr
);

    logic        in_hs_q;
    logic        in_hs_d;
    logic        in_vs_q;
    logic        in_vs_d;
    logic        hs_fall;
    logic        vs_fall;
    logic [10:0] h_cnt;         // Edges since the hsync edge
    logic [9:0]  col;           // Pixels written this line
    logic        wr_bank;
    logic [10:0] win_start;
    logic [9:0]  win_width;
    logic        in_window;

    assign hs_fall = in_hs_d & ~in_hs_q;
    assign vs_fall = in_vs_d & ~in_vs_q;

    assign win_start = (mode == MODE_640) ? 11'(`IN_START_640) : 11'(`IN_START_720);
    assign win_width = (mode == MODE_640) ? 10'(`IN_WIDTH_640) : 10'(`IN_WIDTH_720);

    // h_cnt lags the sampling edge by one, hence start minus one
    assign in_window = (h_cnt >= win_start - 11'd1) && (col < win_width);

    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            in_hs_q <= 1'b1;
            in_hs_d <= 1'b1;
            in_vs_q <= 1'b1;
            in_vs_d <= 1'b1;
        end else begin
            in_hs_q <= in_hs_n;
            in_hs_d <= in_hs_q;
            in_vs_q <= in_vs_n;
            in_vs_d <= in_vs_q;
        end
    end

    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            h_cnt   <= '0;
            col     <= '1;              // No writes before the first hsync
            wr_bank <= 1'b1;
        end else begin
            if (hs_fall) begin
                h_cnt <= 11'd1;
            end else if (h_cnt != '1) begin
                h_cnt <= h_cnt + 11'd1;     // Saturates without hsync
            end

            if (hs_fall) begin
                col <= '0;
            end else if (in_window) begin
                col <= col + 10'd1;
            end

            if (vs_fall) begin
                wr_bank <= 1'b1;            // Wins over a coincident hsync
            end else if (hs_fall) begin
                wr_bank <= ~wr_bank;
            end
        end
    end

    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            buf_wr.wr_en   <= 1'b0;
            buf_wr.wr_addr <= '0;
        end else begin
            buf_wr.wr_en   <= in_window;
            buf_wr.wr_addr <= (wr_bank ? `BUF_ADDR_W'(`BUF_WIDTH) : '0) + `BUF_ADDR_W'(col);
        end
    end

    // Input pixel register, doubles as write data
    always_ff @(posedge DCLK) begin
        buf_wr.wr_data <= in_rgb;
    end

endmodule

`default_nettype wire

//--- line_buf_if.sv
// Line buffer port bundle
`timescale 1ns/1ps
`default_nettype none
`include "video_upscan_defines.svh"

interface line_buf_if
    import video_upscan_pkg::*;
();

    logic                   wr_en;
    logic [`BUF_ADDR_W-1:0] wr_addr;
    rgb_t                   wr_data;
    logic [`BUF_ADDR_W-1:0] rd_addr;
    rgb_t                   rd_data;    // One cycle after rd_addr

    modport writer (output wr_en, output wr_addr, output wr_data);

    modport reader (output rd_addr, input rd_data);

    modport memory (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data
    );

endinterface

`default_nettype wire

//--- video_upscan_pkg.sv
// Upscaler shared types
`default_nettype none

package video_upscan_pkg;

    typedef logic [7:0] pixel_t;    // One colour component

    typedef struct packed {
        pixel_t r;
        pixel_t g;
        pixel_t b;
    } rgb_t;

    typedef enum logic {
        MODE_720 = 1'b0,            // Pass-through
        MODE_640 = 1'b1             // 9/8 stretch
    } video_mode_t;

    // Position inside a group of nine output pixels
    typedef enum logic [3:0] {
        PH_0 = 4'd0,
        PH_1 = 4'd1,
        PH_2 = 4'd2,
        PH_3 = 4'd3,
        PH_4 = 4'd4,
        PH_5 = 4'd5,
        PH_6 = 4'd6,
        PH_7 = 4'd7,                // Address held here
        PH_8 = 4'd8
    } phase_t;

endpackage

`default_nettype wire

//--- video_upscan_defines.svh
// Upscaler timing and buffer constants
`ifndef VIDEO_UPSCAN_DEFINES_SVH
`define VIDEO_UPSCAN_DEFINES_SVH

// Output raster, counted in DCLK cycles and lines
`define H_TOTAL 855         // Cycles per output line
`define H_SYNC 62           // Hsync pulse width
`define H_ERASE 69          // Sync plus back porch
`define H_DISP 720          // Visible pixels per line
`define V_TOTAL 525         // Lines per output frame
`define V_SYNC 2            // Vsync pulse width in lines

// First input pixel position, in edges after the hsync edge
`define IN_START_720 69
`define IN_START_640 128

// Active input pixels per line
`define IN_WIDTH_720 720
`define IN_WIDTH_640 640

// Line buffer geometry, two banks back to back
`define BUF_WIDTH 768       // Words per bank
`define BUF_ADDR_W 11       // Covers both banks

`endif
